//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_host
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' files.f)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f files.f

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- files.f
hdl/spi_cfg_pkg.sv
hdl/spi_ctrl_pkg.sv
hdl/spi_cmd_stage.sv
hdl/spi_shift_engine.sv
hdl/spi_rsp_stage.sv
hdl/spi_host_top.sv
tests/tb_clock_gen.sv
tests/spi_device_model.sv
tests/tb_spi_host.sv

//--- hdl/spi_cfg_pkg.sv
// ##############################
// SPI host sizing package
// Default word width, clock divider and counter widths
// ##############################
package spi_cfg_pkg;

    // Bits per SPI word unless the top level overrides it
    parameter int data_width_default = 16;

    // System clocks per SCLK half period
    parameter int clk_div_default = 8;

    // Width of a counter that runs from 0 to n-1
    // Never narrower than one bit, so a divider of 1 still has a counter
    function automatic int cnt_width(input int n);
        int w;
        if (n > 1) begin
            w = $clog2(n);
        end else begin
            w = 1;
        end
        return w;
    endfunction

    // Width of the SCLK divider counter for a given divider
    function automatic int div_cnt_width(input int clk_div);
        return cnt_width(clk_div);
    endfunction

    // Width of the bit counter for a given word width
    function automatic int bit_cnt_width(input int data_width);
        return cnt_width(data_width);
    endfunction

endpackage

//--- hdl/spi_cmd_stage.sv
// ##############################
// SPI command intake stage
// One-entry holding register ahead of the engine
// ##############################
module spi_cmd_stage #(
    parameter int data_width = spi_cfg_pkg::data_width_default
) (
    input  logic                    clk,
    input  logic                    rst,

    // Command input
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  spi_ctrl_pkg::spi_op_e   cmd_op,
    input  logic [data_width-1:0]   cmd_data,

    // Toward the shift engine
    output logic                    xfer_valid,
    input  logic                    xfer_ready,
    output spi_ctrl_pkg::spi_op_e   xfer_op,
    output logic [data_width-1:0]   xfer_data
);

    import spi_ctrl_pkg::*;

    logic                   full;
    spi_op_e                hold_op;
    logic [data_width-1:0]  hold_data;
    logic                   cmd_fire;
    logic                   xfer_fire;

    // Room when empty, or when the engine takes the entry this cycle
    assign cmd_ready = !full || xfer_ready;

    assign cmd_fire  = cmd_valid && cmd_ready;
    assign xfer_fire = full && xfer_ready;

    // Occupancy flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
        end else if (cmd_fire) begin
            full <= 1'b1;           // Load wins over drain
        end else if (xfer_fire) begin
            full <= 1'b0;
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            hold_op   <= cmd_op;
            hold_data <= cmd_data;
        end
    end

    assign xfer_valid = full;
    assign xfer_op    = hold_op;
    assign xfer_data  = hold_data;

    // Offered command must not change until the engine takes it
    a_xfer_stable : assert property (
        @(posedge clk) disable iff (rst)
        (xfer_valid && !xfer_ready) |=> (xfer_valid && $stable(xfer_op) && $stable(xfer_data))
    ) else $error("xfer payload changed while stalled");

endmodule

//--- hdl/spi_ctrl_pkg.sv
// ##############################
// SPI host control package
// Opcode and engine state encodings
// ##############################
package spi_ctrl_pkg;

    // Command opcodes
    typedef enum logic [1:0] {
        op_exchange = 2'b00,    // Send word, return received word
        op_write    = 2'b01,    // Send word, no response
        op_read     = 2'b10     // Send zeros, return received word
    } spi_op_e;

    // Shift engine states
    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_cs_assert   = 3'd1,  // One cycle of CS setup before SCLK
        st_transfer    = 3'd2,
        st_cs_deassert = 3'd3   // CS back high, completion pulse
    } spi_state_e;

    // Opcodes that produce a response word
    function automatic logic op_has_response(input spi_op_e op);
        return op != op_write;
    endfunction

endpackage

//--- hdl/spi_host_top.sv
// ##############################
// SPI host subsystem top
// Command stage, shift engine, response stage
// ##############################
module spi_host_top #(
    parameter int data_width = spi_cfg_pkg::data_width_default,
    parameter int clk_div    = spi_cfg_pkg::clk_div_default
) (
    input  logic                    clk,
    input  logic                    rst,

    // Command interface
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  spi_ctrl_pkg::spi_op_e   cmd_op,
    input  logic [data_width-1:0]   cmd_data,

    // Response interface
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic [data_width-1:0]   rsp_data,

    // SPI pins
    output logic                    spi_sclk,
    output logic                    spi_cs_n,
    output logic                    spi_mosi,
    input  logic                    spi_miso
);

    import spi_ctrl_pkg::*;

    // Cmd stage to engine
    logic                   xfer_valid;
    logic                   xfer_ready;
    spi_op_e                xfer_op;
    logic [data_width-1:0]  xfer_data;

    // Engine to rsp stage
    logic                   done_valid;
    spi_op_e                done_op;
    logic [data_width-1:0]  done_data;
    logic                   rsp_space;

    spi_cmd_stage #(
        .data_width (data_width)
    ) i_spi_cmd_stage (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .xfer_valid (xfer_valid),
        .xfer_ready (xfer_ready),
        .xfer_op    (xfer_op),
        .xfer_data  (xfer_data)
    );

    spi_shift_engine #(
        .data_width (data_width),
        .clk_div    (clk_div)
    ) i_spi_shift_engine (
        .clk        (clk),
        .rst        (rst),
        .xfer_valid (xfer_valid),
        .xfer_ready (xfer_ready),
        .xfer_op    (xfer_op),
        .xfer_data  (xfer_data),
        .rsp_space  (rsp_space),
        .done_valid (done_valid),
        .done_op    (done_op),
        .done_data  (done_data),
        .spi_sclk   (spi_sclk),
        .spi_cs_n   (spi_cs_n),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

    spi_rsp_stage #(
        .data_width (data_width)
    ) i_spi_rsp_stage (
        .clk        (clk),
        .rst        (rst),
        .done_valid (done_valid),
        .done_op    (done_op),
        .done_data  (done_data),
        .rsp_space  (rsp_space),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data)
    );

endmodule

//--- hdl/spi_rsp_stage.sv
// ##############################
// SPI response stage
// Holds one received word, drops write completions
// ##############################
module spi_rsp_stage #(
    parameter int data_width = spi_cfg_pkg::data_width_default
) (
    input  logic                    clk,
    input  logic                    rst,

    // Completion from the engine
    input  logic                    done_valid,
    input  spi_ctrl_pkg::spi_op_e   done_op,
    input  logic [data_width-1:0]   done_data,
    output logic                    rsp_space,

    // Response output
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output logic [data_width-1:0]   rsp_data
);

    import spi_ctrl_pkg::*;

    logic                   full;
    logic [data_width-1:0]  hold_data;
    logic                   capture;
    logic                   rsp_fire;

    // Writes finish silently
    assign capture  = done_valid && op_has_response(done_op);
    assign rsp_fire = full && rsp_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            full <= 1'b0;
        end else if (capture) begin
            full <= 1'b1;
        end else if (rsp_fire) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            hold_data <= done_data;
        end
    end

    // Engine starts a word only into an empty stage
    assign rsp_space = !full;

    assign rsp_valid = full;
    assign rsp_data  = hold_data;

    // Engine must have waited for space before starting this word
    a_no_overrun : assert property (
        @(posedge clk) disable iff (rst)
        done_valid |-> !full
    ) else $error("completion arrived while response stage full");

endmodule

//--- hdl/spi_shift_engine.sv
// ##############################
// SPI shift engine
// Full-duplex word transfer, SCLK idle low
// ##############################
module spi_shift_engine #(
    parameter int data_width = spi_cfg_pkg::data_width_default,
    parameter int clk_div    = spi_cfg_pkg::clk_div_default
) (
    input  logic                    clk,
    input  logic                    rst,

    // Command from the intake stage
    input  logic                    xfer_valid,
    output logic                    xfer_ready,
    input  spi_ctrl_pkg::spi_op_e   xfer_op,
    input  logic [data_width-1:0]   xfer_data,

    // Completion toward the response stage
    input  logic                    rsp_space,
    output logic                    done_valid,
    output spi_ctrl_pkg::spi_op_e   done_op,
    output logic [data_width-1:0]   done_data,

    // SPI pins
    output logic                    spi_sclk,
    output logic                    spi_cs_n,
    output logic                    spi_mosi,
    input  logic                    spi_miso
);

    import spi_cfg_pkg::*;
    import spi_ctrl_pkg::*;

    localparam int div_w = div_cnt_width(clk_div);
    localparam int bit_w = bit_cnt_width(data_width);

    spi_state_e             state;
    logic [div_w-1:0]       div_cnt;
    logic [bit_w-1:0]       bit_cnt;
    logic [data_width-1:0]  tx_shift;
    logic [data_width-1:0]  rx_shift;
    spi_op_e                cur_op;

    logic                   xfer_fire;
    logic                   div_last;
    logic                   bit_last;
    logic                   sclk_tick;
    logic                   sclk_rise;
    logic                   sclk_fall;

    // Only start a word when the response stage can take the result
    assign xfer_ready = (state == st_idle) && rsp_space;
    assign xfer_fire  = xfer_valid && xfer_ready;

    assign div_last  = div_cnt == div_w'(clk_div - 1);
    assign bit_last  = bit_cnt == bit_w'(data_width - 1);
    assign sclk_tick = (state == st_transfer) && div_last;
    assign sclk_rise = sclk_tick && !spi_sclk;     // SCLK about to go high
    assign sclk_fall = sclk_tick && spi_sclk;      // SCLK about to go low

    // FSM, SCLK divider and pin registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            spi_sclk   <= 1'b0;
            spi_cs_n   <= 1'b1;
            spi_mosi   <= 1'b0;
            done_valid <= 1'b0;
        end else begin
            done_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (xfer_fire) begin
                        spi_cs_n <= 1'b0;
                        state    <= st_cs_assert;
                    end
                end
                st_cs_assert: begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= st_transfer;
                end
                st_transfer: begin
                    if (div_last) begin
                        div_cnt  <= '0;
                        spi_sclk <= ~spi_sclk;
                        if (sclk_rise) begin
                            spi_mosi <= tx_shift[data_width-1];  // MSB first
                        end else if (bit_last) begin
                            // Last falling edge ends the word
                            spi_cs_n   <= 1'b1;
                            spi_mosi   <= 1'b0;
                            done_valid <= 1'b1;
                            state      <= st_cs_deassert;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                st_cs_deassert: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Shift registers and opcode of the word in flight
    always_ff @(posedge clk) begin
        if (xfer_fire) begin
            tx_shift <= (xfer_op == op_read) ? '0 : xfer_data;
            cur_op   <= xfer_op;
        end else if (sclk_rise) begin
            tx_shift <= tx_shift << 1;
        end
        if (sclk_fall) begin
            rx_shift <= {rx_shift[data_width-2:0], spi_miso};   // Sample MISO
        end
    end

    // Both hold still through st_cs_deassert
    assign done_op   = cur_op;
    assign done_data = rx_shift;

    a_sclk_in_cs : assert property (
        @(posedge clk) disable iff (rst)
        spi_sclk |-> !spi_cs_n
    ) else $error("SCLK high with chip select released");

    a_done_pulse : assert property (
        @(posedge clk) disable iff (rst)
        done_valid |=> !done_valid
    ) else $error("done_valid longer than one cycle");

endmodule

//--- tests/spi_device_model.sv
// ##############################
// Behavioral SPI device
// Records MOSI words, answers with preloaded MISO words
// ##############################
module spi_device_model #(
    parameter int data_width = 16
) (
    input  logic spi_sclk,
    input  logic spi_cs_n,
    input  logic spi_mosi,
    output logic spi_miso
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [data_width-1:0]  miso_q[$];     // Words to send back, one per chip select
    logic [data_width-1:0]  mosi_q[$];     // Words received from the host
    logic [data_width-1:0]  tx_word;
    logic [data_width-1:0]  rx_word;
    logic                   mosi_seen;
    logic                   in_word;
    int                     bit_cnt;

    initial begin
        spi_miso  = 1'b0;
        mosi_seen = 1'b0;
        in_word   = 1'b0;
        bit_cnt   = 0;
        tx_word   = '0;
        rx_word   = '0;
    end

    // Chip select opens a word
    always @(negedge spi_cs_n) begin
        in_word = 1'b1;
        bit_cnt = 0;
        if (miso_q.size() > 0) begin
            tx_word = miso_q.pop_front();
        end else begin
            tx_word = '0;
        end
    end

    // Next MISO bit, MSB first
    always @(posedge spi_sclk) begin
        if (in_word) begin
            spi_miso = tx_word[data_width-1];
            tx_word  = tx_word << 1;
            #1 mosi_seen = spi_mosi;   // Host moves MOSI with this edge
        end
    end

    // Falling edge takes the bit; a full word is recorded right here
    always @(negedge spi_sclk) begin
        if (in_word) begin
            rx_word = {rx_word[data_width-2:0], mosi_seen};
            bit_cnt++;
            if (bit_cnt == data_width) begin
                mosi_q.push_back(rx_word);
                in_word = 1'b0;
            end
        end
    end

endmodule

//--- tests/tb_clock_gen.sv
// ##############################
// Testbench clock and reset
// ##############################
module tb_clock_gen #(
    parameter int period_ns    = 4,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 rst = 1'b0;     // Released just after an edge
    end

    always #(period_ns / 2) clk = ~clk;

endmodule

//--- tests/tb_spi_host.sv
// ##############################
// SPI host directed testbench
// ##############################
module tb_spi_host;

    timeunit 1ns;
    timeprecision 100ps;

    import spi_cfg_pkg::*;
    import spi_ctrl_pkg::*;

    localparam int data_width  = data_width_default;
    localparam int clk_div     = clk_div_default;
    localparam int word_ns     = 2 * clk_div * data_width * 4;   // One word at 4 ns per clk
    localparam int total_words = 17;
    // Margin for reset, the back-pressure stall and handshake cycles
    localparam int watchdog_ns = total_words * word_ns + 4 * word_ns + 2000;

    logic                   clk;
    logic                   rst;
    logic                   cmd_valid;
    logic                   cmd_ready;
    spi_op_e                cmd_op;
    logic [data_width-1:0]  cmd_data;
    logic                   rsp_valid;
    logic                   rsp_ready;
    logic [data_width-1:0]  rsp_data;
    logic                   spi_sclk;
    logic                   spi_cs_n;
    logic                   spi_mosi;
    logic                   spi_miso;

    logic [data_width-1:0]  rsp_q[$];   // Accepted responses in arrival order
    int                     test_errors;
    int                     tests_passed;
    int                     tests_failed;

    tb_clock_gen i_clock_gen (.clk(clk), .rst(rst));

    spi_host_top #(
        .data_width (data_width),
        .clk_div    (clk_div)
    ) i_spi_host_top (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp_data   (rsp_data),
        .spi_sclk   (spi_sclk),
        .spi_cs_n   (spi_cs_n),
        .spi_mosi   (spi_mosi),
        .spi_miso   (spi_miso)
    );

    spi_device_model #(.data_width(data_width)) i_spi_device (
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    // Sampled mid-cycle ahead of the handshake edge
    always @(negedge clk) begin
        if (!rst && rsp_valid && rsp_ready) begin
            rsp_q.push_back(rsp_data);
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_word(input string name, input logic [data_width-1:0] exp,
                              input logic [data_width-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error %s: expected %0d, actual %0d", name, exp, act);
            test_errors++;
        end
    endtask

    function automatic logic [data_width-1:0] rand_word();
        logic [31:0] r;
        r = $urandom;
        return r[data_width-1:0];
    endfunction

    function automatic spi_op_e rand_op();
        int unsigned r;
        r = $urandom % 3;
        case (r)
            0:       return op_exchange;
            1:       return op_write;
            default: return op_read;
        endcase
    endfunction

    // Wait n edges, then step past them so drives land 1 ns late
    task automatic next_cycle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic send_cmd(input spi_op_e op, input logic [data_width-1:0] data);
        logic accepted;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_data  = data;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = cmd_ready;
            next_cycle(1);
        end
        cmd_valid = 1'b0;
    endtask

    task automatic wait_rsp_count(input int n);
        while (rsp_q.size() < n) next_cycle(1);
    endtask

    task automatic wait_device_words(input int n);
        while (i_spi_device.mosi_q.size() < n) next_cycle(1);
    endtask

    task automatic expect_response(input string name, input logic [data_width-1:0] exp);
        if (rsp_q.size() == 0) begin
            $display("%s: no response was received", name);
            test_errors++;
        end else begin
            check_word(name, exp, rsp_q.pop_front());
        end
    endtask

    task automatic expect_device_word(input string name, input logic [data_width-1:0] exp);
        if (i_spi_device.mosi_q.size() == 0) begin
            $display("%s: the device recorded no word", name);
            test_errors++;
        end else begin
            check_word(name, exp, i_spi_device.mosi_q.pop_front());
        end
    endtask

    task automatic finish_test(input string name);
        check_count({name, " extra responses"}, 0, rsp_q.size());
        check_count({name, " extra device words"}, 0, i_spi_device.mosi_q.size());
        if (test_errors == 0) begin
            $display("PASS %s", name);
            tests_passed++;
        end else begin
            $display("FAIL %s with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic test_idle_pins();
        check_bit("idle spi_cs_n", 1'b1, spi_cs_n);
        check_bit("idle spi_sclk", 1'b0, spi_sclk);
        check_bit("idle spi_mosi", 1'b0, spi_mosi);
        check_bit("idle rsp_valid", 1'b0, rsp_valid);
        check_bit("idle cmd_ready", 1'b1, cmd_ready);
        finish_test("idle_pins");
    endtask

    // One exchange or read
    task automatic test_single(input string name, input spi_op_e op);
        logic [data_width-1:0] tx;
        logic [data_width-1:0] rx;
        logic [data_width-1:0] exp_mosi;
        tx       = rand_word();
        rx       = rand_word();
        exp_mosi = (op == op_read) ? '0 : tx;   // Reads clock out zeros
        i_spi_device.miso_q.push_back(rx);
        send_cmd(op, tx);
        wait_rsp_count(1);
        expect_response(name, rx);
        expect_device_word({name, " mosi"}, exp_mosi);
        finish_test(name);
    endtask

    task automatic test_write();
        logic [data_width-1:0] tx_wr;
        logic [data_width-1:0] tx_ex;
        logic [data_width-1:0] rx_wr;
        logic [data_width-1:0] rx_ex;
        tx_wr = rand_word();
        tx_ex = rand_word();
        rx_wr = rand_word();
        rx_ex = rand_word();
        i_spi_device.miso_q.push_back(rx_wr);
        i_spi_device.miso_q.push_back(rx_ex);
        send_cmd(op_write, tx_wr);
        send_cmd(op_exchange, tx_ex);
        wait_device_words(2);   // Both words on the wire
        wait_rsp_count(1);
        next_cycle(8);
        check_count("write response count", 1, rsp_q.size());
        expect_response("write", rx_ex);
        expect_device_word("write mosi", tx_wr);
        expect_device_word("write exchange mosi", tx_ex);
        finish_test("write");
    endtask

    task automatic test_backpressure();
        logic [data_width-1:0] tx[3];
        logic [data_width-1:0] rx[3];
        for (int i = 0; i < 3; i++) begin
            tx[i] = rand_word();
            rx[i] = rand_word();
            i_spi_device.miso_q.push_back(rx[i]);
        end
        rsp_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 3; i++) send_cmd(op_exchange, tx[i]);
            end
            begin
                // First word parked, then allow time for two more words
                while (!rsp_valid) next_cycle(1);
                next_cycle(4 * clk_div * data_width);
                check_bit("backpressure cmd_ready", 1'b0, cmd_ready);
                check_count("backpressure words started", 1, i_spi_device.mosi_q.size());
                check_bit("backpressure rsp_valid held", 1'b1, rsp_valid);
                check_word("backpressure held word", rx[0], rsp_data);
                rsp_ready = 1'b1;
            end
        join
        wait_rsp_count(3);
        for (int i = 0; i < 3; i++) begin
            expect_response($sformatf("backpressure rsp %0d", i), rx[i]);
            expect_device_word($sformatf("backpressure mosi %0d", i), tx[i]);
        end
        finish_test("backpressure");
    endtask

    task automatic test_random_burst();
        spi_op_e               ops[10];
        logic [data_width-1:0] tx[10];
        logic [data_width-1:0] rx[10];
        int                    n_rsp;
        n_rsp = 0;
        for (int i = 0; i < 10; i++) begin
            ops[i] = rand_op();
            tx[i]  = rand_word();
            rx[i]  = rand_word();
            i_spi_device.miso_q.push_back(rx[i]);
            if (ops[i] != op_write) n_rsp++;
        end
        for (int i = 0; i < 10; i++) send_cmd(ops[i], tx[i]);
        wait_device_words(10);
        wait_rsp_count(n_rsp);
        next_cycle(8);      // Room for a stray response
        check_count("random_burst response count", n_rsp, rsp_q.size());
        for (int i = 0; i < 10; i++) begin
            expect_device_word($sformatf("random_burst mosi %0d", i),
                               (ops[i] == op_read) ? '0 : tx[i]);
            if (ops[i] != op_write) begin
                expect_response($sformatf("random_burst rsp %0d", i), rx[i]);
            end
        end
        finish_test("random_burst");
    endtask

    initial begin
        cmd_valid    = 1'b0;
        cmd_op       = op_exchange;
        cmd_data     = '0;
        rsp_ready    = 1'b1;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(63414));
        @(negedge rst);
        next_cycle(1);
        test_idle_pins();
        test_single("exchange", op_exchange);
        test_single("read", op_read);
        test_write();
        test_backpressure();
        test_random_burst();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
